// File: smc_ahb_pkg.sv
// AHB-lite encodings for the static memory controller
// Transfer type, response and size codes plus the bus widths
// Pulled in by the AHB slave, the top level and the testbench

`default_nettype none

package smc_ahb_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int AHB_ADDR_W = 32;            // Byte address
  localparam int AHB_DATA_W = 32;            // One word per beat

  // --------------------
  // HTRANS codes
  // --------------------
  localparam logic [1:0] HTRANS_IDLE   = 2'b00;  // No transfer
  localparam logic [1:0] HTRANS_BUSY   = 2'b01;  // Master stalled inside a burst
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;  // First or single beat
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;  // Following beat

  // --------------------
  // HRESP codes
  // --------------------
  localparam logic [1:0] HRESP_OKAY  = 2'b00;
  localparam logic [1:0] HRESP_ERROR = 2'b01;    // Always two cycles

  // HSIZE codes, anything above WORD is rejected by the slave
  localparam logic [2:0] HSIZE_BYTE = 3'b000;
  localparam logic [2:0] HSIZE_HALF = 3'b001;
  localparam logic [2:0] HSIZE_WORD = 3'b010;

endpackage

`default_nettype wire

// File: smc_mem_pkg.sv
// Memory side definitions for the static memory controller
// APB register map, reset values, wait-state width, memory cycle states
// Used by the register block, the sequencer, the slave and the top level

`default_nettype none

package smc_mem_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int WAIT_W     = 4;   // Wait-state count, 0..15 extra strobe cycles
  localparam int APB_ADDR_W = 5;   // Register offset bus
  localparam int EMI_BE_W   = 4;   // One byte enable per lane

  // --------------------
  // Register map
  // --------------------
  localparam logic [APB_ADDR_W-1:0] REG_RD_WAIT = 5'h00;  // Read strobe wait states
  localparam logic [APB_ADDR_W-1:0] REG_WR_WAIT = 5'h04;  // Write strobe wait states
  localparam logic [APB_ADDR_W-1:0] REG_CTRL    = 5'h08;  // Global control

  // Enable bit position in REG_CTRL
  localparam int CTRL_EN_BIT = 0;

  // --------------------
  // Reset values
  // --------------------
  localparam logic [WAIT_W-1:0] RD_WAIT_RST = 4'd2;
  localparam logic [WAIT_W-1:0] WR_WAIT_RST = 4'd2;
  localparam logic              CTRL_RST    = 1'b0;   // Controller comes up disabled

  // External memory cycle states
  // SETUP drives address and chip select, STROBE holds the strobe for wait+1
  // cycles, HOLD releases the strobe with chip select still low
  typedef enum logic [1:0] {
    EMI_IDLE   = 2'b00,
    EMI_SETUP  = 2'b01,
    EMI_STROBE = 2'b10,
    EMI_HOLD   = 2'b11
  } emi_state_t;

endpackage

`default_nettype wire

// File: smc_ahb_slave.sv
// AHB-lite slave front end of the static memory controller
// Qualifies single transfers, builds byte enables and launches one
// external memory cycle per transfer, or answers with a two-cycle ERROR

`timescale 1ns/1ps
`default_nettype none

module smc_ahb_slave
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;
(
  input  wire                   hclk,
  input  wire                   reset,
  // AHB-lite slave side
  input  wire                   hsel,
  input  wire  [AHB_ADDR_W-1:0] haddr,
  input  wire  [1:0]            htrans,
  input  wire                   hwrite,
  input  wire  [2:0]            hsize,
  input  wire  [AHB_DATA_W-1:0] hwdata,
  input  wire                   hready,       // Muxed bus ready
  output logic [AHB_DATA_W-1:0] smc_hrdata,
  output logic                  smc_hready,
  output logic [1:0]            smc_hresp,
  output logic                  smc_valid,    // Accepted legal transfer
  // Control from the register block
  input  wire                   smc_enable,
  // Request to the memory sequencer
  output logic                  emi_start,
  output logic                  emi_write,
  output logic [AHB_ADDR_W-1:0] emi_addr,
  output logic [EMI_BE_W-1:0]   emi_n_be,
  output logic [AHB_DATA_W-1:0] emi_wdata,
  input  wire                   emi_done,
  input  wire  [AHB_DATA_W-1:0] emi_rdata
);

  logic                  accept;     // Address phase taken this cycle
  logic                  reject;     // Disabled or oversize
  logic                  start_q;    // First data phase cycle of a legal access
  logic                  wait_q;     // Data phase open, memory cycle pending
  logic                  err1_q;     // ERROR, ready low
  logic                  err2_q;     // ERROR, ready high
  logic                  write_q;
  logic [AHB_ADDR_W-1:0] addr_q;
  logic [EMI_BE_W-1:0]   n_be_q;
  logic [AHB_DATA_W-1:0] wdata_q;

  // Active-low lane enables, little endian
  function automatic logic [EMI_BE_W-1:0] calc_n_be(input logic [1:0] lane,
                                                    input logic [2:0] size);
    logic [EMI_BE_W-1:0] be;
    be = '0;
    case (size)
      HSIZE_BYTE: be = 4'b0001 << lane;
      HSIZE_HALF: be = lane[1] ? 4'b1100 : 4'b0011;   // Upper or lower half
      default:    be = 4'b1111;                       // Full word
    endcase
    return ~be;
  endfunction

  // --------------------
  // Address phase
  // --------------------
  assign accept    = hsel && hready &&
                     (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
  assign reject    = !smc_enable || (hsize > HSIZE_WORD);
  assign smc_valid = accept && !reject;

  // Data phase control
  always_ff @(posedge hclk) begin
    if (reset) begin
      start_q <= 1'b0;
      wait_q  <= 1'b0;
      err1_q  <= 1'b0;
      err2_q  <= 1'b0;
    end else begin
      start_q <= smc_valid;             // One-cycle launch pulse
      err1_q  <= accept && reject;
      err2_q  <= err1_q;                // Second ERROR cycle follows the first
      if (smc_valid) begin
        wait_q <= 1'b1;                 // Wins over done for back-to-back access
      end else if (emi_done) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Request payload, held while the data phase is stalled
  always_ff @(posedge hclk) begin
    if (smc_valid) begin
      addr_q  <= haddr;
      write_q <= hwrite;
      n_be_q  <= calc_n_be(haddr[1:0], hsize);
    end
    if (start_q) begin
      wdata_q <= hwdata;                // Write data arrives one cycle late
    end
  end

  // --------------------
  // Bus response
  // --------------------
  assign smc_hready = !err1_q && !(wait_q && !emi_done);
  assign smc_hresp  = (err1_q || err2_q) ? HRESP_ERROR : HRESP_OKAY;
  assign smc_hrdata = (wait_q && emi_done && !write_q) ? emi_rdata : '0;

  assign emi_start = start_q;
  assign emi_write = write_q;
  assign emi_addr  = addr_q;
  assign emi_n_be  = n_be_q;
  assign emi_wdata = wdata_q;

  // Ready-high ERROR comes exactly one cycle after ready-low ERROR
  a_err_two_cycle: assert property (@(posedge hclk) disable iff (reset)
    (smc_hresp == HRESP_ERROR && smc_hready) ==
      $past(smc_hresp == HRESP_ERROR && !smc_hready))
    else $error("ERROR response is not the two-cycle sequence");

endmodule

`default_nettype wire

// File: smc_timing_regs.sv
// APB register block for the static memory controller
// Holds read and write wait states and the global enable bit
// Writes land in the enable phase, read data is combinational

`timescale 1ns/1ps
`default_nettype none

module smc_timing_regs
  import smc_mem_pkg::*;
(
  input  wire                   hclk,
  input  wire                   reset,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire  [APB_ADDR_W-1:0] paddr,
  input  wire  [31:0]           pwdata,
  output logic [31:0]           prdata,
  output logic [WAIT_W-1:0]     rd_wait,      // To the sequencer
  output logic [WAIT_W-1:0]     wr_wait,
  output logic                  smc_enable    // To the AHB slave
);

  logic              apb_wr;      // Enable phase of a write
  logic [WAIT_W-1:0] rd_wait_q;
  logic [WAIT_W-1:0] wr_wait_q;
  logic              enable_q;

  assign apb_wr = psel && penable && pwrite;

  // --------------------
  // Register writes
  // --------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      rd_wait_q <= RD_WAIT_RST;
      wr_wait_q <= WR_WAIT_RST;
      enable_q  <= CTRL_RST;
    end else if (apb_wr) begin
      case (paddr)
        REG_RD_WAIT: rd_wait_q <= pwdata[WAIT_W-1:0];   // Upper bits dropped
        REG_WR_WAIT: wr_wait_q <= pwdata[WAIT_W-1:0];
        REG_CTRL:    enable_q  <= pwdata[CTRL_EN_BIT];
        default: ;                                      // Unmapped, ignored
      endcase
    end
  end

  // Read-back
  // Zero-extended, zero for unmapped offsets
  always_comb begin
    prdata = '0;
    case (paddr)
      REG_RD_WAIT: prdata[WAIT_W-1:0]   = rd_wait_q;
      REG_WR_WAIT: prdata[WAIT_W-1:0]   = wr_wait_q;
      REG_CTRL:    prdata[CTRL_EN_BIT]  = enable_q;
      default:     prdata = '0;
    endcase
  end

  assign rd_wait    = rd_wait_q;
  assign wr_wait    = wr_wait_q;
  assign smc_enable = enable_q;

endmodule

`default_nettype wire

// File: smc_emi_ctrl.sv
// External memory cycle sequencer
// One request from the AHB slave becomes SETUP, STROBE for wait+1 cycles
// and HOLD on the asynchronous memory pins, wait+3 cycles in all

`timescale 1ns/1ps
`default_nettype none

module smc_emi_ctrl
  import smc_mem_pkg::*;
(
  input  wire                 hclk,
  input  wire                 reset,
  // Request from the AHB slave
  input  wire                 emi_start,      // One-cycle pulse, IDLE only
  input  wire                 emi_write,
  input  wire  [31:0]         emi_addr,
  input  wire  [EMI_BE_W-1:0] emi_n_be,
  input  wire  [31:0]         emi_wdata,
  output logic                emi_done,       // Pulses in HOLD
  output logic [31:0]         emi_rdata,      // Valid with emi_done
  // Wait states from the register block
  input  wire  [WAIT_W-1:0]   rd_wait,
  input  wire  [WAIT_W-1:0]   wr_wait,
  // External memory interface
  output logic [31:0]         smc_addr,
  output logic [31:0]         smc_data,       // Write data
  input  wire  [31:0]         data_smc,       // Read data
  output logic [EMI_BE_W-1:0] smc_n_be,
  output logic                smc_n_cs,
  output logic [EMI_BE_W-1:0] smc_n_we,       // Per-lane write strobes
  output logic                smc_n_wr,
  output logic                smc_n_rd,
  output logic                smc_n_ext_oe,   // Write data pad drive
  output logic                smc_busy
);

  emi_state_t        state_q;
  logic [WAIT_W-1:0] cnt_q;        // Remaining strobe cycles minus one
  logic [31:0]       rdata_q;
  logic              last_strobe;  // Final STROBE cycle
  logic              wr_strobe;
  logic              rd_strobe;

  assign last_strobe = (state_q == EMI_STROBE) && (cnt_q == '0);

  // --------------------
  // Cycle sequencer
  // --------------------
  always_ff @(posedge hclk) begin
    if (reset) begin
      state_q <= EMI_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        EMI_IDLE: begin
          if (emi_start) begin
            state_q <= EMI_SETUP;
            cnt_q   <= emi_write ? wr_wait : rd_wait;   // Sampled once per cycle
          end
        end
        EMI_SETUP: state_q <= EMI_STROBE;               // Address settles
        EMI_STROBE: begin
          if (cnt_q == '0) begin
            state_q <= EMI_HOLD;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        EMI_HOLD: state_q <= EMI_IDLE;                  // Strobe released
        default:  state_q <= EMI_IDLE;
      endcase
    end
  end

  // Read data sampled on the last strobe edge
  always_ff @(posedge hclk) begin
    if (last_strobe && !emi_write) begin
      rdata_q <= data_smc;
    end
  end

  // --------------------
  // Pin decode
  // --------------------
  assign wr_strobe = (state_q == EMI_STROBE) && emi_write;
  assign rd_strobe = (state_q == EMI_STROBE) && !emi_write;

  assign smc_busy     = (state_q != EMI_IDLE);          // SETUP through HOLD
  assign smc_n_cs     = !smc_busy;
  assign smc_addr     = emi_addr;
  assign smc_data     = emi_wdata;
  assign smc_n_be     = smc_busy ? emi_n_be : '1;
  assign smc_n_rd     = !rd_strobe;
  assign smc_n_wr     = !wr_strobe;
  assign smc_n_we     = wr_strobe ? emi_n_be : '1;      // Only enabled lanes strobe
  assign smc_n_ext_oe = !wr_strobe;                     // Drive bus during write strobe

  assign emi_done  = (state_q == EMI_HOLD);
  assign emi_rdata = rdata_q;

  // Read and write strobes never meet in the same or adjacent cycles
  a_rd_wr_excl: assert property (@(posedge hclk) disable iff (reset)
    !((!smc_n_rd || $past(!smc_n_rd)) && (!smc_n_wr || $past(!smc_n_wr))))
    else $error("read and write strobes low together or back to back");

  // The slave never launches while a memory cycle is running
  a_start_idle: assert property (@(posedge hclk) disable iff (reset)
    emi_start |-> (state_q == EMI_IDLE))
    else $error("emi_start outside IDLE");

endmodule

`default_nettype wire

// File: smc_lite.sv
// Static memory controller top level
// AHB-lite slave, APB timing registers and the external memory sequencer
// on a single clock hclk with a synchronous active-high reset

`timescale 1ns/1ps
`default_nettype none

module smc_lite
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;
(
  input  wire                   hclk,
  input  wire                   reset,
  // APB
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire  [APB_ADDR_W-1:0] paddr,
  input  wire  [31:0]           pwdata,
  output wire  [31:0]           prdata,
  // AHB-lite
  input  wire                   hsel,
  input  wire  [AHB_ADDR_W-1:0] haddr,
  input  wire  [1:0]            htrans,
  input  wire                   hwrite,
  input  wire  [2:0]            hsize,
  input  wire  [AHB_DATA_W-1:0] hwdata,
  input  wire                   hready,
  output wire  [AHB_DATA_W-1:0] smc_hrdata,
  output wire                   smc_hready,
  output wire  [1:0]            smc_hresp,
  output wire                   smc_valid,
  // External memory
  output wire  [31:0]           smc_addr,
  output wire  [31:0]           smc_data,
  input  wire  [31:0]           data_smc,
  output wire  [EMI_BE_W-1:0]   smc_n_be,
  output wire                   smc_n_cs,
  output wire  [EMI_BE_W-1:0]   smc_n_we,
  output wire                   smc_n_wr,
  output wire                   smc_n_rd,
  output wire                   smc_n_ext_oe,
  output wire                   smc_busy
);

  // --------------------
  // Slave to sequencer
  // --------------------
  wire                  emi_start;
  wire                  emi_write;
  wire [AHB_ADDR_W-1:0] emi_addr;
  wire [EMI_BE_W-1:0]   emi_n_be;
  wire [AHB_DATA_W-1:0] emi_wdata;
  wire                  emi_done;
  wire [AHB_DATA_W-1:0] emi_rdata;
  // Register block outputs
  wire [WAIT_W-1:0]     rd_wait;
  wire [WAIT_W-1:0]     wr_wait;
  wire                  smc_enable;

  smc_ahb_slave u_ahb_slave (
    .hclk(hclk), .reset(reset),
    .hsel(hsel), .haddr(haddr), .htrans(htrans), .hwrite(hwrite),
    .hsize(hsize), .hwdata(hwdata), .hready(hready),
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .smc_hresp(smc_hresp),
    .smc_valid(smc_valid), .smc_enable(smc_enable),
    .emi_start(emi_start), .emi_write(emi_write), .emi_addr(emi_addr),
    .emi_n_be(emi_n_be), .emi_wdata(emi_wdata),
    .emi_done(emi_done), .emi_rdata(emi_rdata)
  );

  smc_timing_regs u_regs (
    .hclk(hclk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
    .rd_wait(rd_wait), .wr_wait(wr_wait), .smc_enable(smc_enable)
  );

  smc_emi_ctrl u_emi (
    .hclk(hclk), .reset(reset),
    .emi_start(emi_start), .emi_write(emi_write), .emi_addr(emi_addr),
    .emi_n_be(emi_n_be), .emi_wdata(emi_wdata),
    .emi_done(emi_done), .emi_rdata(emi_rdata),
    .rd_wait(rd_wait), .wr_wait(wr_wait),
    .smc_addr(smc_addr), .smc_data(smc_data), .data_smc(data_smc),
    .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs), .smc_n_we(smc_n_we),
    .smc_n_wr(smc_n_wr), .smc_n_rd(smc_n_rd), .smc_n_ext_oe(smc_n_ext_oe),
    .smc_busy(smc_busy)
  );

endmodule

`default_nettype wire

// File: tb_emi_sram.sv
// Behavioral asynchronous SRAM for the memory controller testbench
// Sits on the external memory pins, answers reads combinationally and
// reports the width of every read and write strobe in hclk cycles

`timescale 1ns/1ps
`default_nettype none

module tb_emi_sram (
  input  wire         hclk,           // Only used to measure strobes
  input  wire  [31:0] smc_addr,
  input  wire  [31:0] smc_data,
  output logic [31:0] data_smc,
  input  wire  [3:0]  smc_n_be,
  input  wire         smc_n_cs,
  input  wire  [3:0]  smc_n_we,
  input  wire         smc_n_wr,
  input  wire         smc_n_rd,
  input  wire         smc_n_ext_oe,
  output logic [7:0]  rd_width = 8'd0,   // Last read strobe width
  output logic [7:0]  wr_width = 8'd0,   // Last write strobe width
  output logic [15:0] rd_count = 16'd0,  // Read strobes seen
  output logic [15:0] wr_count = 16'd0   // Write strobes seen
);

  logic [31:0] mem [0:255];
  logic [7:0]  idx;
  logic [7:0]  rd_cnt = 8'd0;   // Cycles with read strobe low
  logic [7:0]  wr_cnt = 8'd0;

  // Word address, 1 KiB window
  assign idx      = smc_addr[9:2];
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[idx] : 32'h0;

  // Fill pattern carries the word index
  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hC0DE_0000 | i;
    end
  end

  // --------------------
  // Strobe counting and lane writes, sampled mid-cycle
  always @(negedge hclk) begin
    rd_cnt <= smc_n_rd ? 8'd0 : rd_cnt + 8'd1;
    wr_cnt <= smc_n_wr ? 8'd0 : wr_cnt + 8'd1;
    if (!smc_n_cs && !smc_n_ext_oe) begin   // Bus only valid while driven
      for (int b = 0; b < 4; b++) begin
        if (!smc_n_we[b] && !smc_n_be[b]) begin
          mem[idx][8*b +: 8] <= smc_data[8*b +: 8];
        end
      end
    end
  end

  // Width latched on strobe release
  always @(posedge smc_n_rd) begin
    if (rd_cnt != 8'd0) begin
      rd_width <= rd_cnt;
      rd_count <= rd_count + 16'd1;
      $display("SRAM read strobe %0d cycles at %0t", rd_cnt, $time);
    end
  end

  always @(posedge smc_n_wr) begin
    if (wr_cnt != 8'd0) begin
      wr_width <= wr_cnt;
      wr_count <= wr_count + 16'd1;
      $display("SRAM write strobe %0d cycles at %0t", wr_cnt, $time);
    end
  end

endmodule

`default_nettype wire

// File: tb_smc_lite.sv
// Testbench for the static memory controller top level
// Runs the operations of smc_stimulus.txt over APB and AHB-lite and
// checks read-back, response timing and the SRAM strobe widths

`timescale 1ns/1ps
`default_nettype none

module tb_smc_lite
  import smc_ahb_pkg::*;
  import smc_mem_pkg::*;
();

  logic hclk, reset;
  logic psel, penable, pwrite;
  logic [4:0] paddr;
  logic [31:0] pwdata, haddr, hwdata;
  logic hsel, hwrite;
  logic [1:0] htrans;
  logic [2:0] hsize;
  wire [31:0] prdata, smc_hrdata, smc_addr, smc_data, data_smc;
  wire [1:0] smc_hresp;
  wire [3:0] smc_n_be, smc_n_we;
  wire smc_hready, smc_valid, smc_n_cs, smc_n_wr, smc_n_rd, smc_n_ext_oe, smc_busy;
  wire [7:0] rd_width, wr_width;
  wire [15:0] rd_count, wr_count;

  logic [31:0] stim [0:319];           // Five words per operation
  logic [3:0] exp_rd_wait = RD_WAIT_RST; // Wait states as programmed
  logic [3:0] exp_wr_wait = WR_WAIT_RST;
  int cycles = 0;
  int cycle_limit = 0;                 // Zero until the file is loaded

  smc_lite u_dut (
    .hclk(hclk), .reset(reset),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata),
    .hsel(hsel), .haddr(haddr), .htrans(htrans), .hwrite(hwrite), .hsize(hsize),
    .hwdata(hwdata), .hready(smc_hready),   // Single slave, ready loops back
    .smc_hrdata(smc_hrdata), .smc_hready(smc_hready), .smc_hresp(smc_hresp),
    .smc_valid(smc_valid), .smc_addr(smc_addr), .smc_data(smc_data),
    .data_smc(data_smc), .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs),
    .smc_n_we(smc_n_we), .smc_n_wr(smc_n_wr), .smc_n_rd(smc_n_rd),
    .smc_n_ext_oe(smc_n_ext_oe), .smc_busy(smc_busy)
  );

  tb_emi_sram u_sram (
    .hclk(hclk), .smc_addr(smc_addr), .smc_data(smc_data), .data_smc(data_smc),
    .smc_n_be(smc_n_be), .smc_n_cs(smc_n_cs), .smc_n_we(smc_n_we),
    .smc_n_wr(smc_n_wr), .smc_n_rd(smc_n_rd), .smc_n_ext_oe(smc_n_ext_oe),
    .rd_width(rd_width), .wr_width(wr_width), .rd_count(rd_count), .wr_count(wr_count)
  );

  initial begin
    hclk = 1'b0;
    forever #2 hclk = ~hclk;   // 4 ns period
  end

  task automatic report_fail(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      report_fail($sformatf("ERR t=%0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  // Watchdog, budget set per stimulus line
  always @(posedge hclk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      report_fail($sformatf("Timeout after %0d cycles, DUT stopped responding", cycles));
    end
  end

  // --------------------
  // APB, setup then enable phase
  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge hclk);
    psel   <= 1'b1;
    pwrite <= 1'b1;
    paddr  <= addr;
    pwdata <= data;
    @(posedge hclk);
    penable <= 1'b1;
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input logic [4:0] addr, input logic [31:0] exp);
    @(posedge hclk);
    psel   <= 1'b1;
    pwrite <= 1'b0;
    paddr  <= addr;
    @(posedge hclk);
    penable <= 1'b1;
    @(negedge hclk);
    expect_equal("prdata", exp, prdata);
    @(posedge hclk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // --------------------
  // One AHB-lite single transfer, address phase then stalled data phase
  task automatic ahb_access(input logic write, input logic [2:0] size, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic exp_err,
                            input logic [31:0] exp_rdata);
    int lat;
    logic [15:0] rd0;
    logic [15:0] wr0;
    logic [3:0] wait_exp;
    lat = 0;
    wait_exp = write ? exp_wr_wait : exp_rd_wait;
    @(posedge hclk);
    hsel   <= 1'b1;
    htrans <= HTRANS_NONSEQ;
    hwrite <= write;
    hsize  <= size;
    haddr  <= addr;
    @(negedge hclk);
    expect_equal("smc_hready", 32'd1, 32'(smc_hready));
    expect_equal("smc_valid", 32'(!exp_err), 32'(smc_valid));
    rd0 = rd_count;
    wr0 = wr_count;
    @(posedge hclk);
    hsel   <= 1'b0;
    htrans <= HTRANS_IDLE;
    hwdata <= wdata;            // Data phase
    do begin
      @(negedge hclk);
      lat++;
      expect_equal("smc_hresp", exp_err ? 32'(HRESP_ERROR) : 32'(HRESP_OKAY), 32'(smc_hresp));
      // Launch cycle first, then SETUP through HOLD
      expect_equal("smc_busy", 32'(!exp_err && lat > 1), 32'(smc_busy));
      if (exp_err) expect_equal("smc_n_cs", 32'd1, 32'(smc_n_cs));
    end while (!smc_hready);
    expect_equal("smc_hready latency", exp_err ? 32'd2 : 32'(wait_exp) + 32'd4, 32'(lat));
    if (exp_err) begin          // No memory cycle at all
      expect_equal("rd_count", 32'(rd0), 32'(rd_count));
      expect_equal("wr_count", 32'(wr0), 32'(wr_count));
    end else if (write) begin
      expect_equal("wr_count", 32'(wr0) + 32'd1, 32'(wr_count));
      expect_equal("wr_width", 32'(wait_exp) + 32'd1, 32'(wr_width));
    end else begin
      expect_equal("rd_count", 32'(rd0) + 32'd1, 32'(rd_count));
      expect_equal("rd_width", 32'(wait_exp) + 32'd1, 32'(rd_width));
      expect_equal("smc_hrdata", exp_rdata, smc_hrdata);
    end
  endtask

  // --------------------
  // Main sequence
  initial begin
    int n_lines;
    logic [31:0] op, size, addr, data, expv;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    hsel = 1'b0;
    haddr = '0;
    htrans = HTRANS_IDLE;
    hwrite = 1'b0;
    hsize = HSIZE_WORD;
    hwdata = '0;
    $readmemh("smc_stimulus.txt", stim);
    n_lines = 0;
    while (n_lines < 64 && stim[5*n_lines] != 32'hF) n_lines++;   // F ends the list
    cycle_limit = 40 * (n_lines + 1);
    repeat (2) @(posedge hclk);
    reset <= 1'b0;
    @(negedge hclk);
    // {hready, hresp, n_cs, n_rd, n_we, n_ext_oe, busy, valid} out of reset
    expect_equal("reset outputs", 32'b1_00_1_1_1111_1_0_0,
                 32'({smc_hready, smc_hresp, smc_n_cs, smc_n_rd, smc_n_we,
                      smc_n_ext_oe, smc_busy, smc_valid}));
    for (int ln = 0; ln < n_lines; ln++) begin
      op   = stim[5*ln];
      size = stim[5*ln+1];
      addr = stim[5*ln+2];
      data = stim[5*ln+3];
      expv = stim[5*ln+4];
      case (op)
        32'h1: begin                     // APB write, track wait states
          apb_write(addr[4:0], data);
          if (addr[4:0] == REG_RD_WAIT) exp_rd_wait = data[3:0];
          if (addr[4:0] == REG_WR_WAIT) exp_wr_wait = data[3:0];
        end
        32'h2: apb_read(addr[4:0], expv);
        32'h3: ahb_access(1'b1, size[2:0], addr, data, 1'b0, 32'h0);
        32'h4: ahb_access(1'b0, size[2:0], addr, 32'h0, 1'b0, expv);
        32'h5: ahb_access(data[0], size[2:0], addr, 32'h0, 1'b1, 32'h0);   // data[0] is hwrite
        default: report_fail($sformatf("Unknown operation %h on stimulus line %0d", op, ln));
      endcase
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: smc_stimulus.txt
// Columns: op size addr data expect, all hex, one operation per line
// op 1 APB write, 2 APB read, 3 AHB write, 4 AHB read, 5 AHB ERROR expected, F end
2 0 00 00000000 00000002
2 0 04 00000000 00000002
2 0 08 00000000 00000000
5 2 00000040 00000000 0
1 0 00 0000003F 0
2 0 00 00000000 0000000F
1 0 04 00000021 0
2 0 04 00000000 00000001
1 0 08 FFFFFFFF 0
2 0 08 00000000 00000001
3 2 00000010 12345678 0
3 2 00000014 A5A5F00F 0
4 2 00000010 00000000 12345678
4 2 00000014 00000000 A5A5F00F
1 0 00 00000000 0
1 0 04 00000004 0
3 0 00000013 EE000000 0
3 1 00000010 0000BEEF 0
4 2 00000010 00000000 EE34BEEF
3 0 00000015 0000C300 0
4 2 00000014 00000000 A5A5C30F
5 3 00000018 00000001 0
4 2 00000010 00000000 EE34BEEF
F 0 0 0 0

// File: sim.f
smc_ahb_pkg.sv
smc_mem_pkg.sv
smc_ahb_slave.sv
smc_timing_regs.sv
smc_emi_ctrl.sv
smc_lite.sv
tb_emi_sram.sv
tb_smc_lite.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_smc_lite -f sim.f \
  -Mdir obj_dir -o tb_smc_lite
./obj_dir/tb_smc_lite | tee sim.log
if grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: passed"
else
  echo "run_sim: failed"
  exit 1
fi
